// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ls_combo
FILELIST  ?= ls_combo.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== ls_combo.f ====
src/ls_pkg.sv
src/cdb_arbiter.sv
src/ls_config.sv
src/ls_station.sv
src/ls_unit.sv
src/ls_combo.sv
test/tb_ls_combo.sv

// ==== src/cdb_arbiter.sv ====
// result bus arbiter
module cdb_arbiter (
  input  logic                       i_want_bus,
  input  logic [ls_pkg::NUM_CDB-1:0] i_cdb_busy,
  input  logic [ls_pkg::NUM_CDB-1:0] i_mask,
  output logic                       o_grant,
  output logic                       o_grant_index
);
  logic [ls_pkg::NUM_CDB-1:0] free;

  always_comb begin
    // usable means not claimed elsewhere and enabled by config
    free          = ~i_cdb_busy & i_mask;
    o_grant       = 1'b0;
    o_grant_index = 1'b0;

    // scan from the top so the lowest free bus is left standing
    for (int b = ls_pkg::NUM_CDB - 1; b >= 0; b--) begin
      if (free[b]) begin
        o_grant       = i_want_bus;
        o_grant_index = 1'(b);
      end
    end

    // a grant must point at a bus that is free and enabled
    if (o_grant) begin
      a_grant_free: assert (i_want_bus
                            && !i_cdb_busy[o_grant_index]
                            && i_mask[o_grant_index])
        else $error("grant on busy or masked bus %0d", o_grant_index);
    end
  end

endmodule

// ==== src/ls_combo.sv ====
// load/store slice top level
module ls_combo #(
  parameter int STATION_DEPTH = 4
) (
  input  logic                               i_clock,
  input  logic                               i_arst_n,

  // credit-based issue port
  input  logic                               i_issue_valid,
  input  ls_pkg::issue_s                     i_issue,
  output logic                               o_issue_credit,

  // result buses, snooped in and driven out
  input  ls_pkg::cdb_s [ls_pkg::NUM_CDB-1:0] i_cdb,
  input  logic [ls_pkg::NUM_CDB-1:0]         i_cdb_busy,
  output ls_pkg::cdb_s [ls_pkg::NUM_CDB-1:0] o_cdb,

  // data cache port
  output ls_pkg::cache_req_s                 o_cache_req,
  input  ls_pkg::cache_rsp_s                 i_cache_rsp,

  // configuration access
  input  logic                               i_cfg_we,
  input  ls_pkg::cfg_addr_t                  i_cfg_addr,
  input  ls_pkg::word_t                      i_cfg_wdata,
  output ls_pkg::word_t                      o_cfg_rdata
);
  // ********************
  // internal wiring
  // ********************
  logic                       dispatch_valid;
  ls_pkg::issue_s             dispatch;
  logic                       unit_idle;
  logic                       want_bus;
  logic                       grant;
  logic                       grant_index;
  logic                       completed;
  logic                       enable;
  logic [ls_pkg::NUM_CDB-1:0] mask;

  ls_station #(
    .STATION_DEPTH(STATION_DEPTH)
  ) u_station (
    .i_clock         (i_clock),
    .i_arst_n        (i_arst_n),
    .i_issue_valid   (i_issue_valid),
    .i_issue         (i_issue),
    .i_cdb           (i_cdb),
    .i_enable        (enable),
    .i_unit_idle     (unit_idle),
    .o_dispatch_valid(dispatch_valid),
    .o_dispatch      (dispatch),
    // a grant is the moment the head entry leaves
    .i_retire        (grant),
    .o_issue_credit  (o_issue_credit)
  );

  ls_unit u_unit (
    .i_clock         (i_clock),
    .i_arst_n        (i_arst_n),
    .i_dispatch_valid(dispatch_valid),
    .i_dispatch      (dispatch),
    .o_unit_idle     (unit_idle),
    .o_cache_req     (o_cache_req),
    .i_cache_rsp     (i_cache_rsp),
    .o_want_bus      (want_bus),
    .i_grant         (grant),
    .i_grant_index   (grant_index),
    .o_cdb           (o_cdb),
    .o_retire        (completed)
  );

  cdb_arbiter u_arbiter (
    .i_want_bus   (want_bus),
    .i_cdb_busy   (i_cdb_busy),
    .i_mask       (mask),
    .o_grant      (grant),
    .o_grant_index(grant_index)
  );

  ls_config u_config (
    .i_clock    (i_clock),
    .i_arst_n   (i_arst_n),
    .i_cfg_we   (i_cfg_we),
    .i_cfg_addr (i_cfg_addr),
    .i_cfg_wdata(i_cfg_wdata),
    .o_cfg_rdata(o_cfg_rdata),
    .i_completed(completed),
    .o_enable   (enable),
    .o_mask     (mask)
  );

endmodule

// ==== src/ls_config.sv ====
// configuration register block
module ls_config (
  input  logic                       i_clock,
  input  logic                       i_arst_n,

  input  logic                       i_cfg_we,
  input  ls_pkg::cfg_addr_t          i_cfg_addr,
  input  ls_pkg::word_t              i_cfg_wdata,
  output ls_pkg::word_t              o_cfg_rdata,

  input  logic                       i_completed,
  output logic                       o_enable,
  output logic [ls_pkg::NUM_CDB-1:0] o_mask
);
  logic                       enable_q;
  logic [ls_pkg::NUM_CDB-1:0] mask_q;
  ls_pkg::word_t              count_q;

  // ********************
  // registers
  // ********************
  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      enable_q <= 1'b1;
      mask_q   <= '1;
      count_q  <= '0;
    end else begin
      if (i_cfg_we && i_cfg_addr == ls_pkg::CFG_ENABLE) begin
        enable_q <= i_cfg_wdata[0];
      end
      if (i_cfg_we && i_cfg_addr == ls_pkg::CFG_MASK) begin
        mask_q <= i_cfg_wdata[ls_pkg::NUM_CDB-1:0];
      end
      // count is read-only, writes to it are dropped
      if (i_completed) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // ********************
  // read mux
  // ********************
  always_comb begin
    unique case (i_cfg_addr)
      ls_pkg::CFG_ENABLE: o_cfg_rdata = ls_pkg::word_t'(enable_q);
      ls_pkg::CFG_MASK:   o_cfg_rdata = ls_pkg::word_t'(mask_q);
      ls_pkg::CFG_COUNT:  o_cfg_rdata = count_q;
      default:            o_cfg_rdata = '0;
    endcase
  end

  assign o_enable = enable_q;
  assign o_mask   = mask_q;

endmodule

// ==== src/ls_pkg.sv ====
// load/store slice definitions
package ls_pkg;

  // ********************
  // widths
  // ********************
  localparam int WORD_W  = 32;
  localparam int TAG_W   = 4;
  localparam int IMM_W   = 12;
  localparam int NUM_CDB = 2;

  typedef logic [WORD_W-1:0]       word_t;
  typedef logic [TAG_W-1:0]        tag_t;
  typedef logic signed [IMM_W-1:0] imm_t;
  typedef logic [1:0]              cfg_addr_t;

  // tag 0 marks an operand whose value is already present
  localparam tag_t TAG_NONE = '0;

  // configuration register map
  localparam cfg_addr_t CFG_ENABLE = 2'd0;
  localparam cfg_addr_t CFG_MASK   = 2'd1;
  localparam cfg_addr_t CFG_COUNT  = 2'd2;

  // ********************
  // encodings
  // ********************
  typedef enum logic {
    LS_LOAD,
    LS_STORE
  } ls_op_e;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    HOLD
  } ls_state_e;

  // ********************
  // bundles
  // ********************
  typedef struct packed {
    ls_op_e op;
    tag_t   dest;
    tag_t   base_tag;
    word_t  base_val;
    tag_t   data_tag;
    word_t  data_val;
    imm_t   imm;
  } issue_s;

  // reg_write is set for loads, clear for store completions
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t data;
    word_t address;
    logic  reg_write;
  } cdb_s;

  typedef struct packed {
    logic  read;
    logic  write;
    word_t address;
    word_t wdata;
  } cache_req_s;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } cache_rsp_s;

endpackage

// ==== src/ls_station.sv ====
// in-order reservation station
module ls_station #(
  parameter int STATION_DEPTH = 4
) (
  input  logic                               i_clock,
  input  logic                               i_arst_n,

  input  logic                               i_issue_valid,
  input  ls_pkg::issue_s                     i_issue,

  input  ls_pkg::cdb_s [ls_pkg::NUM_CDB-1:0] i_cdb,
  input  logic                               i_enable,

  input  logic                               i_unit_idle,
  output logic                               o_dispatch_valid,
  output ls_pkg::issue_s                     o_dispatch,

  input  logic                               i_retire,
  output logic                               o_issue_credit
);
  localparam int PTR_W = (STATION_DEPTH > 1) ? $clog2(STATION_DEPTH) : 1;
  // occupancy is bounded by the credits handed out, one per entry
  localparam int COUNT_W = $clog2(STATION_DEPTH + 1);

  typedef logic [PTR_W-1:0]   ptr_t;
  typedef logic [COUNT_W-1:0] count_t;

  localparam ptr_t   LAST_PTR = ptr_t'(STATION_DEPTH - 1);
  localparam count_t FULL_CNT = count_t'(STATION_DEPTH);

  ls_pkg::issue_s           entries [STATION_DEPTH];
  logic [STATION_DEPTH-1:0] valid;
  ptr_t                     head;
  ptr_t                     tail;
  count_t                   count;
  ls_pkg::issue_s           head_entry;
  logic                     head_ready;

  // wrap at the depth, which need not be a power of two
  function automatic ptr_t ptr_inc(ptr_t p);
    ptr_t r;
    if (p == LAST_PTR) begin
      r = '0;
    end else begin
      r = p + 1'b1;
    end
    return r;
  endfunction

  // capture any broadcast that matches a pending operand tag
  function automatic ls_pkg::issue_s snoop(
    ls_pkg::issue_s                     e,
    ls_pkg::cdb_s [ls_pkg::NUM_CDB-1:0] cdb
  );
    ls_pkg::issue_s r;
    r = e;
    for (int b = 0; b < ls_pkg::NUM_CDB; b++) begin
      if (cdb[b].valid && e.base_tag != ls_pkg::TAG_NONE && cdb[b].tag == e.base_tag) begin
        r.base_val = cdb[b].data;
        r.base_tag = ls_pkg::TAG_NONE;
      end
      if (cdb[b].valid && e.data_tag != ls_pkg::TAG_NONE && cdb[b].tag == e.data_tag) begin
        r.data_val = cdb[b].data;
        r.data_tag = ls_pkg::TAG_NONE;
      end
    end
    return r;
  endfunction

  // ********************
  // queue control
  // ********************
  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (i_issue_valid) begin
        valid[tail] <= 1'b1;
        tail        <= ptr_inc(tail);
      end
      // retire frees the head slot, issue never lands there while full
      if (i_retire) begin
        valid[head] <= 1'b0;
        head        <= ptr_inc(head);
      end
      count <= count + count_t'(i_issue_valid) - count_t'(i_retire);
    end
  end

  // ********************
  // entry payload
  // ********************
  always_ff @(posedge i_clock) begin
    for (int i = 0; i < STATION_DEPTH; i++) begin
      if (i_issue_valid && tail == ptr_t'(i)) begin
        // a beat on the issue cycle is caught here too
        entries[i] <= snoop(i_issue, i_cdb);
      end else begin
        entries[i] <= snoop(entries[i], i_cdb);
      end
    end
  end

  // head dispatch once both operands have arrived
  assign head_entry = entries[head];
  assign head_ready = valid[head]
                    && head_entry.base_tag == ls_pkg::TAG_NONE
                    && head_entry.data_tag == ls_pkg::TAG_NONE;

  assign o_dispatch_valid = head_ready && i_unit_idle && i_enable;
  assign o_dispatch       = head_entry;

  // one credit back per freed entry, in the same cycle
  assign o_issue_credit = i_retire;

  // ********************
  // checks
  // ********************
  // issuer holds no credit while every entry is taken
  a_no_issue_full: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    i_issue_valid |-> count != FULL_CNT);

  a_no_retire_empty: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    i_retire |-> valid[head] && count != '0);

endmodule

// ==== src/ls_unit.sv ====
// load/store execution unit
module ls_unit (
  input  logic                               i_clock,
  input  logic                               i_arst_n,

  input  logic                               i_dispatch_valid,
  input  ls_pkg::issue_s                     i_dispatch,
  output logic                               o_unit_idle,

  output ls_pkg::cache_req_s                 o_cache_req,
  input  ls_pkg::cache_rsp_s                 i_cache_rsp,

  output logic                               o_want_bus,
  input  logic                               i_grant,
  input  logic                               i_grant_index,

  output ls_pkg::cdb_s [ls_pkg::NUM_CDB-1:0] o_cdb,
  output logic                               o_retire
);
  ls_pkg::ls_state_e state;
  ls_pkg::ls_state_e state_next;

  ls_pkg::ls_op_e op_q;
  ls_pkg::tag_t   dest_q;
  ls_pkg::word_t  addr_q;
  ls_pkg::word_t  wdata_q;
  ls_pkg::word_t  result_q;
  ls_pkg::word_t  addr_calc;
  logic           is_load;

  // base plus sign-extended immediate
  assign addr_calc = i_dispatch.base_val
                   + {{(ls_pkg::WORD_W - ls_pkg::IMM_W){i_dispatch.imm[ls_pkg::IMM_W-1]}},
                      i_dispatch.imm};

  assign is_load = (op_q == ls_pkg::LS_LOAD);

  // ********************
  // FSM
  // ********************
  always_comb begin
    state_next = state;
    unique case (state)
      ls_pkg::IDLE: begin
        if (i_dispatch_valid) begin
          state_next = ls_pkg::ACCESS;
        end
      end
      ls_pkg::ACCESS: begin
        if (i_cache_rsp.ready) begin
          state_next = ls_pkg::HOLD;
        end
      end
      ls_pkg::HOLD: begin
        // result stays put until some bus is granted
        if (i_grant) begin
          state_next = ls_pkg::IDLE;
        end
      end
      default: begin
        state_next = ls_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clock or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= ls_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // operation and result registers
  always_ff @(posedge i_clock) begin
    if (state == ls_pkg::IDLE && i_dispatch_valid) begin
      op_q    <= i_dispatch.op;
      dest_q  <= i_dispatch.dest;
      addr_q  <= addr_calc;
      wdata_q <= i_dispatch.data_val;
    end
    // loads keep the read word and stores the written address
    if (state == ls_pkg::ACCESS && i_cache_rsp.ready) begin
      result_q <= is_load ? i_cache_rsp.rdata : addr_q;
    end
  end

  // ********************
  // cache port
  // ********************
  always_comb begin
    o_cache_req.read    = (state == ls_pkg::ACCESS) && is_load;
    o_cache_req.write   = (state == ls_pkg::ACCESS) && !is_load;
    o_cache_req.address = addr_q;
    o_cache_req.wdata   = wdata_q;
  end

  // ********************
  // completion
  // ********************
  assign o_unit_idle = (state == ls_pkg::IDLE);
  assign o_want_bus  = (state == ls_pkg::HOLD);
  assign o_retire    = (state == ls_pkg::HOLD) && i_grant;

  always_comb begin
    o_cdb = '0;
    if (o_retire) begin
      o_cdb[i_grant_index].valid     = 1'b1;
      o_cdb[i_grant_index].tag       = dest_q;
      o_cdb[i_grant_index].data      = result_q;
      o_cdb[i_grant_index].address   = addr_q;
      o_cdb[i_grant_index].reg_write = is_load;
    end
  end

  // request held steady across a slow cache
  a_req_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
    (o_cache_req.read || o_cache_req.write) && !i_cache_rsp.ready
      |=> $stable(o_cache_req));

endmodule

// ==== test/tb_ls_combo.sv ====
// load/store slice testbench
module tb_ls_combo;

  localparam int STATION_DEPTH = 4;
  localparam int MEM_WORDS     = 64;
  localparam int NUM_ROWS      = 15;
  localparam int WAIT_LIMIT    = 200;
  // value driven for an operand that is still pending
  localparam ls_pkg::word_t JUNK = 32'hdead_beef;

  typedef struct packed {
    ls_pkg::ls_op_e op;
    ls_pkg::tag_t   dest;
    ls_pkg::tag_t   base_tag;
    ls_pkg::word_t  base_val;
    ls_pkg::tag_t   data_tag;
    ls_pkg::word_t  data_val;
    ls_pkg::imm_t   imm;
    logic [7:0]     release_dly;
    logic [1:0]     busy;
    logic [1:0]     mask;
    logic [7:0]     block;
    logic [7:0]     gate;
  } row_s;

  typedef struct packed {
    int            row;
    ls_pkg::tag_t  tag;
    ls_pkg::word_t data;
    ls_pkg::word_t addr;
    logic          rw;
    logic          bus;
  } expect_s;

  typedef struct packed {
    int            due;
    ls_pkg::tag_t  tag;
    ls_pkg::word_t data;
  } bcast_s;

  logic                               clock;
  logic                               arst_n;
  logic                               issue_valid;
  ls_pkg::issue_s                     issue;
  logic                               issue_credit;
  ls_pkg::cdb_s [ls_pkg::NUM_CDB-1:0] cdb_in;
  logic [ls_pkg::NUM_CDB-1:0]         cdb_busy;
  ls_pkg::cdb_s [ls_pkg::NUM_CDB-1:0] cdb_out;
  ls_pkg::cache_req_s                 cache_req;
  ls_pkg::cache_rsp_s                 cache_rsp;
  logic                               cfg_we;
  ls_pkg::cfg_addr_t                  cfg_addr;
  ls_pkg::word_t                      cfg_wdata;
  ls_pkg::word_t                      cfg_rdata;

  ls_pkg::word_t cache_mem [MEM_WORDS];
  ls_pkg::word_t ref_mem [MEM_WORDS];
  row_s          ops [NUM_ROWS];
  expect_s       expq [$];
  bcast_s        bcq [$];
  integer        seed;
  int            cyc;
  int            credits;
  int            issued;
  int            returned;
  int            beats;
  int            head_start;
  int            enable_req;
  int            cache_wait;
  logic          cache_busy;
  logic          saw_no_credit;
  logic          gated;
  logic [1:0]    mask_set;

  ls_combo #(
    .STATION_DEPTH(STATION_DEPTH)
  ) i_dut (
    .i_clock       (clock),
    .i_arst_n      (arst_n),
    .i_issue_valid (issue_valid),
    .i_issue       (issue),
    .o_issue_credit(issue_credit),
    .i_cdb         (cdb_in),
    .i_cdb_busy    (cdb_busy),
    .o_cdb         (cdb_out),
    .o_cache_req   (cache_req),
    .i_cache_rsp   (cache_rsp),
    .i_cfg_we      (cfg_we),
    .i_cfg_addr    (cfg_addr),
    .i_cfg_wdata   (cfg_wdata),
    .o_cfg_rdata   (cfg_rdata)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  // ********************
  // reporting
  // ********************
  task automatic end_failed();
    $display("Result: FAILED");
    $fatal(1, "testbench stopped on first error");
  endtask

  task automatic report_error(string what);
    $display("ERROR at %0t: %s", $time, what);
    end_failed();
  endtask

  task automatic check_value(ls_pkg::word_t expected, ls_pkg::word_t actual, string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, what, expected, actual);
      end_failed();
    end
  endtask

  function automatic row_s make_row(ls_pkg::ls_op_e op, int dest, int btag, ls_pkg::word_t bval,
                                    int dtag, ls_pkg::word_t dval, int imm, int dly,
                                    logic [1:0] busy, logic [1:0] mask, int block, int gate);
    row_s r;
    r.op          = op;
    r.dest        = ls_pkg::tag_t'(dest);
    r.base_tag    = ls_pkg::tag_t'(btag);
    r.base_val    = bval;
    r.data_tag    = ls_pkg::tag_t'(dtag);
    r.data_val    = dval;
    r.imm         = ls_pkg::imm_t'(imm);
    r.release_dly = 8'(dly);
    r.busy        = busy;
    r.mask        = mask;
    r.block       = 8'(block);
    r.gate        = 8'(gate);
    return r;
  endfunction

  // lowest bus that is neither claimed nor masked off
  function automatic logic pick_bus(logic [1:0] busy, logic [1:0] mask);
    logic [1:0] usable;
    usable = ~busy & mask;
    return usable[0] ? 1'b0 : 1'b1;
  endfunction

  // ********************
  // stimulus
  // ********************
  task automatic drive_broadcasts();
    int slot;
    slot = 0;
    cdb_in = '0;
    for (int k = 0; k < bcq.size(); k++) begin
      if (bcq[k].due == cyc) begin
        if (slot > 1) begin
          report_error("more than two tag broadcasts due in one cycle");
        end
        cdb_in[slot].valid = 1'b1;
        cdb_in[slot].tag   = bcq[k].tag;
        cdb_in[slot].data  = bcq[k].data;
        slot++;
      end
    end
  endtask

  task automatic next_cycle();
    int r;
    @(posedge clock);
    #1;
    cyc++;
    issue_valid = 1'b0;
    cfg_we      = 1'b0;
    drive_broadcasts();
    if (enable_req >= 0) begin
      cfg_we     = 1'b1;
      cfg_addr   = ls_pkg::CFG_ENABLE;
      cfg_wdata  = ls_pkg::word_t'(enable_req);
      enable_req = -1;
    end else if (expq.size() > 0 && ops[expq[0].row].mask != mask_set) begin
      mask_set  = ops[expq[0].row].mask;
      cfg_we    = 1'b1;
      cfg_addr  = ls_pkg::CFG_MASK;
      cfg_wdata = ls_pkg::word_t'(mask_set);
    end
    // the oldest op sees both buses blocked for its first block cycles
    if (expq.size() == 0) begin
      cdb_busy = 2'b00;
    end else begin
      r = expq[0].row;
      if (cyc - head_start < int'(ops[r].block)) begin
        cdb_busy = 2'b11;
      end else begin
        cdb_busy = ops[r].busy;
      end
    end
  endtask

  task automatic issue_row(int r);
    row_s          o;
    expect_s       e;
    bcast_s        b;
    ls_pkg::word_t addr;
    int            wait_n;
    o = ops[r];
    wait_n = 0;
    next_cycle();
    while (credits == 0) begin
      saw_no_credit = 1'b1;
      next_cycle();
      wait_n++;
      if (wait_n > WAIT_LIMIT) begin
        report_error("timeout waiting for an issue credit");
      end
    end
    issue_valid    = 1'b1;
    issue.op       = o.op;
    issue.dest     = o.dest;
    issue.base_tag = o.base_tag;
    issue.base_val = (o.base_tag != ls_pkg::TAG_NONE) ? JUNK : o.base_val;
    issue.data_tag = o.data_tag;
    issue.data_val = (o.data_tag != ls_pkg::TAG_NONE) ? JUNK : o.data_val;
    issue.imm      = o.imm;
    credits--;
    issued++;
    b.due = cyc + int'(o.release_dly);
    if (o.base_tag != ls_pkg::TAG_NONE) begin
      b.tag  = o.base_tag;
      b.data = o.base_val;
      bcq.push_back(b);
    end
    if (o.data_tag != ls_pkg::TAG_NONE) begin
      b.tag  = o.data_tag;
      b.data = o.data_val;
      bcq.push_back(b);
    end
    // picks up a broadcast due on this very cycle
    drive_broadcasts();
    addr   = o.base_val + ls_pkg::word_t'(int'($signed(o.imm)));
    e.row  = r;
    e.tag  = o.dest;
    e.addr = addr;
    e.bus  = pick_bus(o.busy, o.mask);
    if (o.op == ls_pkg::LS_LOAD) begin
      e.data = ref_mem[addr[7:2]];
      e.rw   = 1'b1;
    end else begin
      ref_mem[addr[7:2]] = o.data_val;
      e.data = addr;
      e.rw   = 1'b0;
    end
    if (expq.size() == 0) begin
      head_start = cyc;
    end
    expq.push_back(e);
  endtask

  task automatic wait_drain();
    int wait_n;
    wait_n = 0;
    while (expq.size() > 0) begin
      next_cycle();
      wait_n++;
      if (wait_n > WAIT_LIMIT) begin
        report_error("timeout waiting for outstanding ops to complete");
      end
    end
  endtask

  // ********************
  // cache model
  // ********************
  always @(posedge clock) begin
    #1;
    cache_rsp.ready = 1'b0;
    if (!arst_n) begin
      cache_busy = 1'b0;
    end else if (cache_busy) begin
      if (cache_wait > 0) begin
        cache_wait--;
      end
    end else if (cache_req.read || cache_req.write) begin
      cache_busy = 1'b1;
      cache_wait = ($random(seed) & 32'h7fff_ffff) % 3;
    end
    if (cache_busy && cache_wait == 0) begin
      cache_rsp.rdata = cache_mem[cache_req.address[7:2]];
      if (cache_req.write) begin
        cache_mem[cache_req.address[7:2]] = cache_req.wdata;
      end
      cache_rsp.ready = 1'b1;
      cache_busy      = 1'b0;
    end
  end

  // ********************
  // monitor
  // ********************
  task automatic check_beat(int b);
    expect_s e;
    if (gated) begin
      report_error("result broadcast while dispatch is disabled");
    end
    if (cdb_busy == 2'b11) begin
      report_error("result broadcast while both buses are busy");
    end
    if (expq.size() == 0) begin
      report_error("result broadcast with no op outstanding");
    end
    e = expq.pop_front();
    check_value(ls_pkg::word_t'(e.bus), ls_pkg::word_t'(b), "result bus index");
    check_value(ls_pkg::word_t'(e.tag), ls_pkg::word_t'(cdb_out[b].tag), "result tag");
    check_value(e.addr, cdb_out[b].address, "result address");
    check_value(ls_pkg::word_t'(e.rw), ls_pkg::word_t'(cdb_out[b].reg_write), "reg_write flag");
    check_value(e.data, cdb_out[b].data, "result data");
    beats++;
    head_start = cyc + 1;
  endtask

  always @(negedge clock) begin
    if (arst_n) begin
      if (issue_credit) begin
        credits++;
        returned++;
      end
      if (gated && (cache_req.read || cache_req.write)) begin
        report_error("cache access while dispatch is disabled");
      end
      for (int b = 0; b < ls_pkg::NUM_CDB; b++) begin
        if (cdb_out[b].valid) begin
          check_beat(b);
        end
      end
    end
  end

  initial begin
    seed          = 32'h1bc9cc50;
    arst_n        = 1'b0;
    issue_valid   = 1'b0;
    issue         = '0;
    cdb_in        = '0;
    cdb_busy      = 2'b00;
    cache_rsp     = '0;
    cfg_we        = 1'b0;
    cfg_addr      = ls_pkg::CFG_ENABLE;
    cfg_wdata     = '0;
    cyc           = 0;
    credits       = STATION_DEPTH;
    issued        = 0;
    returned      = 0;
    beats         = 0;
    head_start    = 0;
    enable_req    = -1;
    cache_wait    = 0;
    cache_busy    = 1'b0;
    saw_no_credit = 1'b0;
    gated         = 1'b0;
    mask_set      = 2'b11;
    for (int i = 0; i < MEM_WORDS; i++) begin
      cache_mem[i] = $random(seed);
      ref_mem[i]   = cache_mem[i];
    end

    // op, dest, base tag/value, data tag/value, imm, release, busy, mask, block, gate
    ops[0]  = make_row(ls_pkg::LS_LOAD,  1, 0, 32'h10, 0, 32'h0, 4, 0, 2'b00, 2'b11, 0, 0);
    ops[1]  = make_row(ls_pkg::LS_STORE, 2, 0, 32'h20, 0, 32'hcafe0001, -4, 0, 2'b00, 2'b11, 0, 0);
    ops[2]  = make_row(ls_pkg::LS_LOAD,  3, 0, 32'h18, 0, 32'h0, 4, 0, 2'b01, 2'b11, 0, 0);
    ops[3]  = make_row(ls_pkg::LS_STORE, 4, 0, 32'h80, 0, 32'h12345678, 0, 0, 2'b00, 2'b10, 0, 0);
    ops[4]  = make_row(ls_pkg::LS_LOAD,  5, 0, 32'h7c, 0, 32'h0, 4, 0, 2'b10, 2'b01, 0, 0);
    ops[5]  = make_row(ls_pkg::LS_LOAD,  6, 9, 32'h30, 0, 32'h0, 8, 0, 2'b00, 2'b11, 0, 0);
    ops[6]  = make_row(ls_pkg::LS_STORE, 7, 10, 32'h40, 11, 32'h5a5a5a5a, 0, 12, 2'b00, 2'b11, 0, 0);
    ops[7]  = make_row(ls_pkg::LS_LOAD,  8, 0, 32'h3c, 0, 32'h0, 4, 0, 2'b01, 2'b11, 0, 0);
    ops[8]  = make_row(ls_pkg::LS_LOAD,  12, 0, 32'h44, 0, 32'h0, 0, 0, 2'b00, 2'b11, 0, 0);
    ops[9]  = make_row(ls_pkg::LS_STORE, 13, 0, 32'h48, 0, 32'h0badf00d, 0, 0, 2'b00, 2'b11, 0, 0);
    ops[10] = make_row(ls_pkg::LS_LOAD,  14, 0, 32'h50, 0, 32'h0, -8, 0, 2'b00, 2'b11, 0, 0);
    ops[11] = make_row(ls_pkg::LS_LOAD,  15, 0, 32'h14, 0, 32'h0, -4, 0, 2'b00, 2'b11, 12, 0);
    ops[12] = make_row(ls_pkg::LS_STORE, 1, 0, 32'h50, 0, 32'h77, 8, 0, 2'b01, 2'b11, 0, 10);
    ops[13] = make_row(ls_pkg::LS_LOAD,  2, 0, 32'h50, 0, 32'h0, 8, 0, 2'b00, 2'b01, 10, 0);
    ops[14] = make_row(ls_pkg::LS_STORE, 6, 3, 32'h60, 0, 32'hfeed, 0, 3, 2'b10, 2'b11, 0, 0);

    repeat (10) @(posedge clock);
    check_value('0, ls_pkg::word_t'({issue_credit, cdb_out[0].valid, cdb_out[1].valid,
                                     cache_req.read, cache_req.write}), "outputs in reset");
    #1;
    arst_n = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      if (ops[r].gate != 0) begin
        // with nothing in flight any dispatch now is a fault
        wait_drain();
        enable_req = 0;
        gated      = 1'b1;
        next_cycle();
        issue_row(r);
        repeat (ops[r].gate) next_cycle();
        enable_req = 1;
        next_cycle();
        gated = 1'b0;
      end else begin
        issue_row(r);
      end
    end
    wait_drain();
    repeat (4) next_cycle();

    cfg_addr = ls_pkg::CFG_COUNT;
    @(negedge clock);
    check_value(ls_pkg::word_t'(beats), cfg_rdata, "completion count register");
    check_value(ls_pkg::word_t'(NUM_ROWS), ls_pkg::word_t'(beats), "number of results");
    check_value(ls_pkg::word_t'(issued), ls_pkg::word_t'(returned), "credits returned");
    check_value(ls_pkg::word_t'(STATION_DEPTH), ls_pkg::word_t'(credits), "credits held");
    check_value(32'd1, ls_pkg::word_t'(saw_no_credit), "station filled to zero credits");

    $display("Result: PASSED");
    $finish;
  end

endmodule
